// ==== Bender.yml ====
package:
  name: intr_csr

sources:
  # Package first, then the blocks, then the top level
  - src/intrPkg.sv
  - src/csrAccess.sv
  - src/csrIntr.sv
  - src/csrTrapCtrl.sv
  - src/intrSelect.sv
  - src/intrCsrTop.sv
  - target: test
    files:
      - testbench/tbClock.sv
      - testbench/intrCsrTb.sv

// ==== build.f ====
src/intrPkg.sv
src/csrAccess.sv
src/csrIntr.sv
src/csrTrapCtrl.sv
src/intrSelect.sv
src/intrCsrTop.sv
testbench/tbClock.sv
testbench/intrCsrTb.sv

// ==== src/csrAccess.sv ====
// Reads and the illegal flag are combinational; an illegal access returns zero and writes nothing

`timescale 1ns/1ps

module csrAccess import intrPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  csrReq           req,
  input  privMode         priv,
  input  logic [11:0]     ip,
  input  logic [11:0]     ie,
  input  logic [11:0]     mideleg,
  input  logic            mie,
  input  logic            sie,
  output csrWrEn          wrEn,
  output logic [xlen-1:0] rdata,
  output logic            illegal
);

  csrWrEn hit;   // Address match per CSR
  logic   known; // Address is one of the listed CSRs

  //////////////////////////////
  // Address decode
  //////////////////////////////
  always_comb begin
    hit         = '0;
    hit.mip     = (req.addr == addrMip);
    hit.mie     = (req.addr == addrMie);
    hit.mideleg = (req.addr == addrMideleg);
    hit.mstatus = (req.addr == addrMstatus);
    // S views exist only with supervisor mode
    hit.sip     = sModeSupported && (req.addr == addrSip);
    hit.sie     = sModeSupported && (req.addr == addrSie);
    hit.sstatus = sModeSupported && (req.addr == addrSstatus);
  end

  assign known   = (hit != '0);
  // Bits 9:8 hold the lowest privilege that may touch the CSR
  assign illegal = !known || (priv < req.addr[9:8]);

  // At most one strobe since the addresses are distinct
  assign wrEn = (req.write && !illegal) ? hit : '0;

  //////////////////////////////
  // Read views
  //////////////////////////////
  always_comb begin
    rdata = '0;
    if (!illegal) begin
      unique case (1'b1)
        hit.mip:     rdata = {{(xlen-12){1'b0}}, ip};
        hit.mie:     rdata = {{(xlen-12){1'b0}}, ie};
        hit.mideleg: rdata = {{(xlen-12){1'b0}}, mideleg};
        hit.sip:     rdata = {{(xlen-12){1'b0}}, ip & mideleg & sFieldMask}; // Delegated only
        hit.sie:     rdata = {{(xlen-12){1'b0}}, ie & mideleg & sFieldMask};
        hit.mstatus: begin
          rdata[mstatusMieBit] = mie;
          rdata[mstatusSieBit] = sie;
        end
        hit.sstatus: rdata[mstatusSieBit] = sie; // SIE is the only visible field here
        default:     rdata = '0;
      endcase
    end
  end

  // Downstream registers assume a single CSR written per cycle
  wrOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(wrEn))
    else $error("More than one CSR write strobe active");

endmodule

// ==== src/csrIntr.sv ====
// Interrupt lines are level inputs sampled every edge; M-level pending bits clear only by reset

`timescale 1ns/1ps

module csrIntr import intrPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  csrWrEn          wrEn,
  input  logic [xlen-1:0] wdata,
  input  intrLines        lines,
  input  logic [11:0]     mideleg,
  output logic [11:0]     ip,
  output logic [11:0]     ie
);

  logic [11:0] intIn;      // Lines routed to their pending fields
  logic [11:0] mipMask;    // Writable mip fields
  logic [11:0] sipMask;    // Writable sip fields
  logic [11:0] ieSMask;    // Fields an sie write may touch
  logic [11:0] ipWrMask;   // Mask of the write in flight
  logic [11:0] ipNext;
  logic [11:0] ieNext;

  //////////////////////////////
  // Line routing
  //////////////////////////////
  // Each line lands in M or S field depending on delegation
  always_comb begin
    intIn       = '0;
    intIn[meip] = lines.ext   & ~mideleg[seip];
    intIn[seip] = lines.ext   &  mideleg[seip];
    intIn[mtip] = lines.timer & ~mideleg[stip];
    intIn[stip] = lines.timer &  mideleg[stip];
    intIn[msip] = lines.sw    & ~mideleg[ssip];
    intIn[ssip] = lines.sw    &  mideleg[ssip];
  end

  // Without S mode nothing in mip/sip is software writable
  assign mipMask = sModeSupported ? mipWriteMask : '0;
  assign sipMask = sModeSupported ? sipWriteMask : '0;
  assign ieSMask = sModeSupported ? sFieldMask   : '0;

  //////////////////////////////
  // Pending register
  //////////////////////////////
  always_comb begin
    ipWrMask = '0;
    if (wrEn.mip)      ipWrMask = mipMask;
    else if (wrEn.sip) ipWrMask = sipMask;
    // Written fields take wdata, others hold; a live line wins over a clear
    ipNext = (wdata[11:0] & ipWrMask) | (ip & ~ipWrMask) | intIn;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ip <= '0;
    end else begin
      ip <= ipNext; // Lines OR in every cycle
    end
  end

  //////////////////////////////
  // Enable register
  //////////////////////////////
  always_comb begin
    ieNext = ie;
    if (wrEn.mie) begin
      ieNext = wdata[11:0] & mieWriteMask;                    // Full M and S view
    end else if (wrEn.sie) begin
      ieNext = (wdata[11:0] & ieSMask) | (ie & ~ieSMask);     // MEIE, MTIE, MSIE kept
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ie <= '0;
    end else begin
      ie <= ieNext;
    end
  end

  // Reserved and U fields must never latch anything
  ipDefined: assert property (@(posedge clk) disable iff (reset)
    (ip & ~mieWriteMask) == '0)
    else $error("Pending bit set outside M/S fields");

  ieDefined: assert property (@(posedge clk) disable iff (reset)
    (ie & ~mieWriteMask) == '0)
    else $error("Enable bit set outside M/S fields");

endmodule

// ==== src/csrTrapCtrl.sv ====
// Holds only MIDELEG and the MIE/SIE global enables; all other mstatus fields read as zero

`timescale 1ns/1ps

module csrTrapCtrl import intrPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  csrWrEn          wrEn,
  input  logic [xlen-1:0] wdata,
  output logic [11:0]     mideleg,
  output logic            mie,
  output logic            sie
);

  logic [11:0] delegMask; // Fields of mideleg that can be set

  assign delegMask = sModeSupported ? midelegMask : '0;

  //////////////////////////////
  // Delegation
  //////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mideleg <= '0;
    end else if (wrEn.mideleg) begin
      mideleg <= wdata[11:0] & delegMask; // M interrupts stay in M
    end
  end

  //////////////////////////////
  // Global enables
  //////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mie <= 1'b0;
      sie <= 1'b0;
    end else if (wrEn.mstatus) begin
      mie <= wdata[mstatusMieBit];
      sie <= sModeSupported && wdata[mstatusSieBit];
    end else if (wrEn.sstatus) begin
      // sstatus is a restricted view and cannot reach MIE
      sie <= sModeSupported && wdata[mstatusSieBit];
    end
  end

  // Selector relies on M interrupts never being routed to S
  noMDeleg: assert property (@(posedge clk) disable iff (reset)
    (mideleg & ~midelegMask) == '0)
    else $error("mideleg holds an M-level field");

endmodule

// ==== src/intrCsrTop.sv ====
// Top of the interrupt CSR slice; one request per cycle, no back-pressure, reads are combinational

`timescale 1ns/1ps

module intrCsrTop import intrPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  csrReq           req,
  input  privMode         priv,
  input  intrLines        lines,
  output logic [xlen-1:0] rdata,
  output logic            illegal,
  output intrStatus       status
);

  csrWrEn      wrEn;    // One strobe per CSR
  logic [11:0] ip;
  logic [11:0] ie;
  logic [11:0] mideleg;
  logic        mie;     // mstatus.MIE
  logic        sie;     // mstatus.SIE

  //////////////////////////////
  // Blocks
  //////////////////////////////
  csrAccess u_csrAccess (
    .clk(clk), .reset(reset), .req(req), .priv(priv),
    .ip(ip), .ie(ie), .mideleg(mideleg), .mie(mie), .sie(sie),
    .wrEn(wrEn), .rdata(rdata), .illegal(illegal)
  );

  csrIntr u_csrIntr (
    .clk(clk), .reset(reset), .wrEn(wrEn), .wdata(req.wdata),
    .lines(lines), .mideleg(mideleg), .ip(ip), .ie(ie)
  );

  csrTrapCtrl u_csrTrapCtrl (
    .clk(clk), .reset(reset), .wrEn(wrEn), .wdata(req.wdata),
    .mideleg(mideleg), .mie(mie), .sie(sie)
  );

  intrSelect u_intrSelect (
    .ip(ip), .ie(ie), .mideleg(mideleg), .mie(mie), .sie(sie),
    .priv(priv), .status(status)
  );

endmodule

// ==== src/intrPkg.sv ====
// Machine and supervisor interrupts only; no N extension, CSR addresses and masks are fixed by the privileged spec

package intrPkg;

  //////////////////////////////
  // Widths and options
  //////////////////////////////
  localparam int unsigned xlen           = 64;  // Data word width
  localparam bit          sModeSupported = 1'b1; // Supervisor mode present

  // CSR addresses
  localparam logic [11:0] addrSstatus = 12'h100;
  localparam logic [11:0] addrSie     = 12'h104;
  localparam logic [11:0] addrSip     = 12'h144;
  localparam logic [11:0] addrMstatus = 12'h300;
  localparam logic [11:0] addrMideleg = 12'h303;
  localparam logic [11:0] addrMie     = 12'h304;
  localparam logic [11:0] addrMip     = 12'h344;

  // Field masks over the low 12 bits of mip/mie
  localparam logic [11:0] mipWriteMask = 12'h222; // SEIP, STIP, SSIP
  localparam logic [11:0] sipWriteMask = 12'h002; // SSIP only
  localparam logic [11:0] mieWriteMask = 12'hAAA; // All M and S fields
  localparam logic [11:0] sFieldMask   = 12'h222;
  localparam logic [11:0] midelegMask  = 12'h222; // Only S interrupts can be delegated

  // Field indices, also the interrupt cause codes
  localparam int unsigned ssip = 1;
  localparam int unsigned msip = 3;
  localparam int unsigned stip = 5;
  localparam int unsigned mtip = 7;
  localparam int unsigned seip = 9;
  localparam int unsigned meip = 11;

  // Global enable positions in mstatus
  localparam int unsigned mstatusSieBit = 1;
  localparam int unsigned mstatusMieBit = 3;

  //////////////////////////////
  // Types
  //////////////////////////////
  typedef logic [1:0] privMode;

  localparam privMode privU = 2'd0;
  localparam privMode privS = 2'd1;
  localparam privMode privM = 2'd3; // 2 is reserved

  typedef struct packed {
    logic            write; // Single-cycle strobe
    logic [11:0]     addr;
    logic [xlen-1:0] wdata; // Final value, no read-modify-write
  } csrReq;

  typedef struct packed {
    logic ext;
    logic timer;
    logic sw;
  } intrLines;

  typedef struct packed {
    logic mip, sip, mie, sie, mideleg, mstatus, sstatus;
  } csrWrEn;

  typedef struct packed {
    logic       pending;
    logic [3:0] cause;
    logic       toSupervisor;
  } intrStatus;

endpackage

// ==== src/intrSelect.sv ====
// Pure combinational; assumes priv is never the reserved encoding 2

`timescale 1ns/1ps

module intrSelect import intrPkg::*; (
  input  logic [11:0] ip,
  input  logic [11:0] ie,
  input  logic [11:0] mideleg,
  input  logic        mie,
  input  logic        sie,
  input  privMode     priv,
  output intrStatus   status
);

  logic [11:0] cand;  // Pending and enabled
  logic        mOk;   // M-targeted interrupts allowed now
  logic        sOk;   // S-targeted interrupts allowed now
  logic [11:0] mTake;
  logic [11:0] sTake;
  logic [11:0] take;

  //////////////////////////////
  // Global enable rule
  //////////////////////////////
  assign cand = ip & ie;

  // Lower modes are always interruptible by a higher target
  assign mOk = (priv != privM) || mie;
  assign sOk = (priv == privU) || ((priv == privS) && sie); // Never in M

  assign mTake = cand & ~mideleg & {12{mOk}};
  assign sTake = cand &  mideleg & {12{sOk}};
  assign take  = mTake | sTake;

  //////////////////////////////
  // Fixed priority
  //////////////////////////////
  // MEI > MSI > MTI > SEI > SSI > STI
  always_comb begin
    status       = '0;
    status.pending = (take != '0);
    if (take[meip]) begin
      status.cause = 4'(meip);
    end else if (take[msip]) begin
      status.cause = 4'(msip);
    end else if (take[mtip]) begin
      status.cause = 4'(mtip);
    end else if (take[seip]) begin
      status.cause = 4'(seip);
    end else if (take[ssip]) begin
      status.cause = 4'(ssip);
    end else if (take[stip]) begin
      status.cause = 4'(stip);
    end
    // Target mode follows delegation of the winner
    status.toSupervisor = status.pending && sTake[status.cause];
  end

endmodule

// ==== testbench/intrCsrTb.sv ====
// Checks run only outside reset; priv is never driven to the reserved encoding 2

`timescale 1ns/1ps

module intrCsrTb import intrPkg::*; ();

  localparam int numTests      = 6;
  localparam int cyclesPerTest = 400;  // Upper bound, longest test is well below
  localparam int clkPeriodNs   = 20;
  localparam int marginNs      = 2000; // Reset phase and slack

  logic            clk;
  logic            reset;
  csrReq           req;
  privMode         priv;
  intrLines        lines;
  logic [xlen-1:0] rdata;
  logic            illegal;
  intrStatus       status;

  // Shadow CSR state
  logic [11:0]     shIp;
  logic [11:0]     shIe;
  logic [11:0]     shDeleg;
  logic            shMie;
  logic            shSie;
  logic [11:0]     lineBits; // Lines mapped onto pending fields
  logic            wrOk;     // Legal write this cycle
  logic            expIll;
  logic [xlen-1:0] expRd;
  intrStatus       expSt;

  int          errCount     = 0;
  int          testCount    = 0;
  int          testStartErr = 0;

  logic [11:0] csrList [7] = '{addrMstatus, addrSstatus, addrMideleg, addrMie,
                               addrMip, addrSie, addrSip};
  logic [11:0] badList [5] = '{12'h000, 12'h145, 12'h200, 12'h305, 12'hF14}; // Not CSRs here

  tbClock u_tbClock (.clk(clk), .reset(reset));

  intrCsrTop u_intrCsrTop (
    .clk(clk), .reset(reset), .req(req), .priv(priv), .lines(lines),
    .rdata(rdata), .illegal(illegal), .status(status)
  );

  ////////////////////////////////
  // Reference rules
  ////////////////////////////////
  function automatic logic accessIllegal(input logic [11:0] addr, input privMode p);
    privMode minPriv;
    logic    listed;
    listed = 1'b1;
    case (addr)
      addrSstatus, addrSie, addrSip:             minPriv = privS;
      addrMstatus, addrMideleg, addrMie, addrMip: minPriv = privM;
      default: begin
        listed  = 1'b0; // Unknown at any level
        minPriv = privM;
      end
    endcase
    return !listed || (p < minPriv);
  endfunction

  function automatic logic [xlen-1:0] readView(input logic [11:0] addr, input logic ill,
      input logic [11:0] ip, ie, deleg, input logic mEn, sEn);
    logic [xlen-1:0] v;
    v = '0;
    if (!ill) begin
      case (addr)
        addrMip:     v[11:0] = ip;
        addrMie:     v[11:0] = ie;
        addrMideleg: v[11:0] = deleg;
        addrSip:     v[11:0] = ip & deleg & sFieldMask; // Delegated S fields only
        addrSie:     v[11:0] = ie & deleg & sFieldMask;
        addrMstatus: v       = {{(xlen-4){1'b0}}, mEn, 1'b0, sEn, 1'b0};
        addrSstatus: v       = {{(xlen-2){1'b0}}, sEn, 1'b0};
        default:     v       = '0;
      endcase
    end
    return v;
  endfunction

  function automatic intrStatus pickInterrupt(input logic [11:0] ip, ie, deleg,
      input logic mEn, sEn, input privMode p);
    int unsigned order [6];
    intrStatus   s;
    logic        ok;
    order = '{meip, msip, mtip, seip, ssip, stip}; // Highest first
    s     = '0;
    for (int k = 0; k < 6; k++) begin
      if (deleg[order[k]]) ok = (p == privU) || ((p == privS) && sEn); // S target
      else ok = (p < privM) || mEn;                                    // M target
      if (!s.pending && ip[order[k]] && ie[order[k]] && ok) begin
        s.pending      = 1'b1;
        s.cause        = 4'(order[k]);
        s.toSupervisor = deleg[order[k]];
      end
    end
    return s;
  endfunction

  always_comb begin
    expIll = accessIllegal(req.addr, priv);
    expRd  = readView(req.addr, expIll, shIp, shIe, shDeleg, shMie, shSie);
    expSt  = pickInterrupt(shIp, shIe, shDeleg, shMie, shSie, priv);
  end

  assign wrOk = req.write && !expIll;

  always_comb begin
    lineBits = '0;
    lineBits[shDeleg[seip] ? seip : meip] = lines.ext;
    lineBits[shDeleg[stip] ? stip : mtip] = lines.timer;
    lineBits[shDeleg[ssip] ? ssip : msip] = lines.sw;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      shIp    <= '0;
      shIe    <= '0;
      shDeleg <= '0;
      shMie   <= 1'b0;
      shSie   <= 1'b0;
    end else begin
      if (wrOk && req.addr == addrMip)
        shIp <= (shIp & ~mipWriteMask) | (req.wdata[11:0] & mipWriteMask) | lineBits;
      else if (wrOk && req.addr == addrSip)
        shIp <= (shIp & ~sipWriteMask) | (req.wdata[11:0] & sipWriteMask) | lineBits;
      else
        shIp <= shIp | lineBits; // Lines win over any clear
      if (wrOk && req.addr == addrMie) shIe <= req.wdata[11:0] & mieWriteMask;
      else if (wrOk && req.addr == addrSie)
        shIe <= (shIe & ~sFieldMask) | (req.wdata[11:0] & sFieldMask);
      if (wrOk && req.addr == addrMideleg) shDeleg <= req.wdata[11:0] & midelegMask;
      if (wrOk && req.addr == addrMstatus) begin
        shMie <= req.wdata[3];
        shSie <= req.wdata[1];
      end else if (wrOk && req.addr == addrSstatus) begin
        shSie <= req.wdata[1]; // MIE out of reach
      end
    end
  end

  ////////////////////////////////
  // Checks
  ////////////////////////////////
  chkRead: assert property (@(posedge clk) disable iff (reset) rdata == expRd)
    else begin
      errCount++;
      $display("ERR %0t: rdata %h at addr %h, expected %h", $time, $sampled(rdata),
               $sampled(req.addr), $sampled(expRd));
    end

  chkIllegal: assert property (@(posedge clk) disable iff (reset) illegal == expIll)
    else begin
      errCount++;
      $display("ERR %0t: illegal %b at addr %h priv %0d, expected %b", $time,
               $sampled(illegal), $sampled(req.addr), $sampled(priv), $sampled(expIll));
    end

  chkStatus: assert property (@(posedge clk) disable iff (reset) status == expSt)
    else begin
      errCount++;
      $display("ERR %0t: status %h, expected %h", $time, $sampled(status), $sampled(expSt));
    end

  ////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////
  task automatic access(input privMode p, input logic w, input logic [11:0] a,
      input logic [xlen-1:0] d);
    @(posedge clk);
    priv      <= p;
    req.write <= w; // Held one cycle, next call replaces it
    req.addr  <= a;
    req.wdata <= d;
  endtask

  task automatic setLines(input logic [2:0] v);
    lines <= v; // Same edge as the last access
  endtask

  function automatic logic [xlen-1:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic privMode randPriv();
    case ($urandom % 3)
      0:       return privU;
      1:       return privS;
      default: return privM;
    endcase
  endfunction

  task automatic endTest(input string name);
    access(privM, 1'b0, addrMip, '0);
    @(posedge clk); // Last drive gets sampled
    testCount++;
    if (errCount == testStartErr) $display("Test %0d %s: ok", testCount, name);
    else $display("Test %0d %s: FAIL, %0d checks", testCount, name, errCount - testStartErr);
    testStartErr = errCount;
  endtask

  ////////////////////////////////
  // Tests
  ////////////////////////////////
  initial begin
    void'($urandom(77));
    req      = '0;
    priv     = privM;
    lines    = '0;
    @(negedge reset);

    foreach (csrList[k]) access(privM, 1'b0, csrList[k], '0); // All zero after reset
    endTest("reset values");

    access(privM, 1'b1, addrMideleg, rand64());
    repeat (8) begin
      access(privM, 1'b1, addrMie, rand64());
      access(privM, 1'b0, addrMie, '0);
      access(privS, 1'b1, addrSie, rand64()); // M fields must survive
      access(privM, 1'b0, addrMie, '0);
      access(privS, 1'b0, addrSie, '0);
    end
    endTest("enable writes");

    repeat (8) begin
      access(privM, 1'b1, addrMideleg, rand64()); // M bits get dropped
      access(privM, 1'b0, addrMideleg, '0);
      setLines(3'($urandom));
      access(privM, 1'b0, addrMip, '0);
      setLines('0);
      access(privS, 1'b0, addrSip, '0);
      access(privS, 1'b0, addrSie, '0);
      access(privM, 1'b1, addrMip, '0); // Drop S pending
    end
    endTest("delegation routing");

    access(privM, 1'b1, addrMideleg, {{(xlen-12){1'b0}}, midelegMask});
    setLines(3'b111);
    access(privM, 1'b1, addrMip, '0); // Clear while lines high
    access(privM, 1'b0, addrMip, '0);
    repeat (10) begin
      setLines(3'($urandom));
      access(privM, 1'b1, addrMip, rand64());
      access(privM, 1'b0, addrMip, '0);
      access(privS, 1'b1, addrSip, rand64()); // SSIP only
      access(privS, 1'b0, addrSip, '0);
      access(privM, 1'b0, addrMip, '0);
      access(privM, 1'b1, addrMideleg, rand64());
    end
    setLines('0);
    endTest("pending writes");

    repeat (24) begin
      access(privM, 1'b1, addrMideleg, rand64());
      access(privM, 1'b1, addrMie, rand64());
      access(privM, 1'b1, addrMstatus, rand64());
      setLines(3'($urandom));
      access(privM, 1'b1, addrMip, rand64());
      setLines('0);
      repeat (4) access(randPriv(), 1'b0, addrSip, '0);
    end
    endTest("selection");

    foreach (csrList[k]) begin
      access(privU, 1'b1, csrList[k], rand64());   // All illegal
      access(privS, 1'b1, csrList[k], rand64());   // M level illegal
      access(privM, 1'b0, csrList[k], '0);
    end
    foreach (badList[k]) begin
      access(randPriv(), 1'b1, badList[k], rand64());
      access(privM, 1'b1, badList[k], rand64());
    end
    foreach (csrList[k]) access(privM, 1'b0, csrList[k], '0); // Nothing moved
    endTest("access check");

    $display("Tests run: %0d, failed checks: %0d", testCount, errCount);
    if (errCount == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

  // Watchdog
  initial begin
    #(numTests * cyclesPerTest * clkPeriodNs + marginNs);
    $display("Watchdog expired before all tests finished");
    $display("Errors found");
    $finish;
  end

endmodule

// ==== testbench/tbClock.sv ====
// Free-running 20 ns clock from time zero; reset is released on a rising edge after 16 cycles

`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic reset
);

  localparam realtime halfPeriod  = 10.0; // 20 ns period
  localparam int      resetCycles = 16;

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0; // Released on the edge
  end

endmodule
